// File: Makefile
# Verilator build and run of the linked-list queue testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
	  --top-module ll_queue_tb -f filelist.f --Mdir obj_dir -o ll_queue_sim
	./obj_dir/ll_queue_sim

clean:
	rm -rf obj_dir

// File: filelist.f
source/ll_queue_pkg.sv
source/ll_free_pool.sv
source/ll_cmd_admit.sv
source/ll_queue_engine.sv
source/ll_queue_top.sv
tb/ll_queue_checker.sv
tb/ll_queue_tb.sv

// File: source/ll_cmd_admit.sv
/*
 * Command admission and s0 command register
 * Refuses pops to empty contexts and pushes into a full pool
 */

module ll_cmd_admit
  import ll_queue_pkg::*;
#(
  parameter int N_CTXT = DEFAULT_N_CTXT,
  parameter int DATA_W = DEFAULT_DATA_W
)
(
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      cmd_pass,
  input  logic                      cmd_push,
  input  logic [$clog2(N_CTXT)-1:0] cmd_ctxt,
  input  logic [DATA_W-1:0]         cmd_data,
  output logic                      cmd_accept,
  input  logic [N_CTXT-1:0]         empty_next,
  input  logic                      full_next,
  output logic                      s0_valid,
  output logic                      s0_push,
  output logic [$clog2(N_CTXT)-1:0] s0_ctxt,
  output logic [DATA_W-1:0]         s0_data
);

  logic take;

  // Admission against the status left by the command now in s0
  // A push then a pop to the same context passes back to back
  always_comb
  begin
    if (cmd_push)
    begin
      cmd_accept = ~full_next;
    end
    else
    begin
      cmd_accept = ~empty_next[cmd_ctxt];
    end
    take = cmd_pass & cmd_accept;
  end

  // Valid follows acceptance every cycle
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      s0_valid <= 1'b0;
    end
    else
    begin
      s0_valid <= take;
    end
  end

  // Command fields, loaded only on transfer
  always_ff @(posedge clk)
  begin
    if (take)
    begin
      s0_push <= cmd_push;
      s0_ctxt <= cmd_ctxt;
      s0_data <= cmd_data;
    end
  end

endmodule

// File: source/ll_free_pool.sv
/*
 * Free slot pool
 * Busy bit per slot, lowest free index first, pool-full flag
 */

module ll_free_pool
  import ll_queue_pkg::*;
#(
  parameter int N_ENTRY = DEFAULT_N_ENTRY
)
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       alloc,
  input  logic                       free_en,
  input  logic [$clog2(N_ENTRY)-1:0] free_id,
  output logic [$clog2(N_ENTRY)-1:0] alloc_id,
  output logic                       full_next,
  output logic                       full_r
);

  localparam int ADDR_W = $clog2(N_ENTRY);

  logic [N_ENTRY-1:0] busy_r;
  logic [N_ENTRY-1:0] busy_next;

  always_comb
  begin
    // Scan downward so the lowest free slot wins
    alloc_id = '0;
    for (int i = N_ENTRY - 1; i >= 0; i--)
    begin
      if (!busy_r[i])
      begin
        alloc_id = ADDR_W'(i);
      end
    end

    // Apply this cycle's allocation and release
    busy_next = busy_r;
    if (alloc)
    begin
      busy_next[alloc_id] = 1'b1;
    end
    if (free_en)
    begin
      busy_next[free_id] = 1'b0;
    end
    full_next = &busy_next;
  end

  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      busy_r <= '0;
      full_r <= 1'b0;
    end
    else
    begin
      busy_r <= busy_next;
      full_r <= full_next;
    end
  end

endmodule

// File: source/ll_queue_engine.sv
/*
 * Linked-list queue engine
 * Per-context head/tail/empty state, shared link table and lookup output
 * One command from s0 completes per cycle
 */

module ll_queue_engine
  import ll_queue_pkg::*;
#(
  parameter int N_CTXT  = DEFAULT_N_CTXT,
  parameter int N_ENTRY = DEFAULT_N_ENTRY,
  parameter int DATA_W  = DEFAULT_DATA_W
)
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       s0_valid,
  input  logic                       s0_push,
  input  logic [$clog2(N_CTXT)-1:0]  s0_ctxt,
  input  logic [DATA_W-1:0]          s0_data,
  output logic [N_CTXT-1:0]          empty_next,
  output logic                       full_next,
  output logic                       lkup_pass_r,
  output lkup_op_t                   lkup_op_r,
  output logic [$clog2(N_ENTRY)-1:0] lkup_addr_r,
  output logic [DATA_W-1:0]          lkup_data_r,
  output logic [N_CTXT-1:0]          empty_r,
  output logic                       full_r
);

  localparam int ADDR_W = $clog2(N_ENTRY);

  // State table, one head and tail per context
  logic [ADDR_W-1:0] head_r [N_CTXT];
  logic [ADDR_W-1:0] tail_r [N_CTXT];

  // Link table, next pointer per slot
  logic [ADDR_W-1:0] link_r [N_ENTRY];

  // Current state of the context in s0
  logic [ADDR_W-1:0] cur_head;
  logic [ADDR_W-1:0] cur_tail;
  logic              cur_empty;

  // Free pool handshake
  logic              alloc;
  logic              free_en;
  logic [ADDR_W-1:0] free_id;
  logic [ADDR_W-1:0] alloc_id;

  // Slot named on the lookup port
  logic [ADDR_W-1:0] slot;
  lkup_op_t          op;

  always_comb
  begin
    cur_head  = head_r[s0_ctxt];
    cur_tail  = tail_r[s0_ctxt];
    cur_empty = empty_r[s0_ctxt];

    alloc   = s0_valid & s0_push;
    free_en = s0_valid & ~s0_push;
    // Pops always release the head slot
    free_id = cur_head;

    if (s0_push)
    begin
      slot = alloc_id;
      op   = LKUP_WRITE;
    end
    else
    begin
      slot = cur_head;
      op   = LKUP_READ;
    end
  end

  // Empty flags after this command
  always_comb
  begin
    empty_next = empty_r;
    if (s0_valid)
    begin
      if (s0_push)
      begin
        empty_next[s0_ctxt] = 1'b0;
      end
      else
      begin
        // Last entry leaves when head meets tail
        empty_next[s0_ctxt] = (cur_head == cur_tail);
      end
    end
  end

  // Control state
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      empty_r     <= '1;
      lkup_pass_r <= 1'b0;
    end
    else
    begin
      empty_r     <= empty_next;
      lkup_pass_r <= s0_valid;
    end
  end

  // Table updates
  always_ff @(posedge clk)
  begin
    if (alloc)
    begin
      // Chain the new slot behind the old tail
      if (!cur_empty)
      begin
        link_r[cur_tail] <= alloc_id;
      end
      else
      begin
        head_r[s0_ctxt] <= alloc_id;
      end
      tail_r[s0_ctxt] <= alloc_id;
    end
    else if (free_en)
    begin
      // Head advances along the chain
      head_r[s0_ctxt] <= link_r[cur_head];
    end
  end

  // Lookup payload, data only on pushes
  always_ff @(posedge clk)
  begin
    if (s0_valid)
    begin
      lkup_op_r   <= op;
      lkup_addr_r <= slot;
    end
    if (alloc)
    begin
      lkup_data_r <= s0_data;
    end
  end

  ll_free_pool #(
    .N_ENTRY (N_ENTRY)
  ) u_free_pool (
    .clk       (clk),
    .arst_n    (arst_n),
    .alloc     (alloc),
    .free_en   (free_en),
    .free_id   (free_id),
    .alloc_id  (alloc_id),
    .full_next (full_next),
    .full_r    (full_r)
  );

endmodule

// File: source/ll_queue_pkg.sv
/*
 * Linked-list queue controller shared definitions
 * Default sizes and the lookup operation encoding
 */

package ll_queue_pkg;

  // Number of queue contexts
  parameter int DEFAULT_N_CTXT = 8;

  // Number of slots in the shared pool
  parameter int DEFAULT_N_ENTRY = 16;

  // Width of the data carried on push lookups
  parameter int DEFAULT_DATA_W = 32;

  // Lookup operation toward the external data memory
  // Write for a push, read for a pop
  typedef enum logic
  {
    LKUP_WRITE = 1'b0,
    LKUP_READ  = 1'b1
  } lkup_op_t;

endpackage

// File: source/ll_queue_top.sv
/*
 * Linked-list queue controller top level
 * Command admission feeding the queue engine, with lookup and status out
 */

module ll_queue_top
  import ll_queue_pkg::*;
#(
  parameter int N_CTXT  = DEFAULT_N_CTXT,
  parameter int N_ENTRY = DEFAULT_N_ENTRY,
  parameter int DATA_W  = DEFAULT_DATA_W
)
(
  input  logic                       clk,
  input  logic                       arst_n,
  // Command side
  input  logic                       cmd_pass,
  input  logic                       cmd_push,
  input  logic [$clog2(N_CTXT)-1:0]  cmd_ctxt,
  input  logic [DATA_W-1:0]          cmd_data,
  output logic                       cmd_accept,
  // Lookup side, one-cycle pulse
  output logic                       lkup_pass_r,
  output lkup_op_t                   lkup_op_r,
  output logic [$clog2(N_ENTRY)-1:0] lkup_addr_r,
  output logic [DATA_W-1:0]          lkup_data_r,
  // Status
  output logic [N_CTXT-1:0]          empty_r,
  output logic                       full_r
);

  localparam int CTXT_W = $clog2(N_CTXT);

  // Command register toward the engine
  logic              s0_valid;
  logic              s0_push;
  logic [CTXT_W-1:0] s0_ctxt;
  logic [DATA_W-1:0] s0_data;

  // Status after the command in s0 completes
  logic [N_CTXT-1:0] empty_next;
  logic              full_next;

  ll_cmd_admit #(
    .N_CTXT (N_CTXT),
    .DATA_W (DATA_W)
  ) u_admit (
    .clk        (clk),
    .arst_n     (arst_n),
    .cmd_pass   (cmd_pass),
    .cmd_push   (cmd_push),
    .cmd_ctxt   (cmd_ctxt),
    .cmd_data   (cmd_data),
    .cmd_accept (cmd_accept),
    .empty_next (empty_next),
    .full_next  (full_next),
    .s0_valid   (s0_valid),
    .s0_push    (s0_push),
    .s0_ctxt    (s0_ctxt),
    .s0_data    (s0_data)
  );

  ll_queue_engine #(
    .N_CTXT  (N_CTXT),
    .N_ENTRY (N_ENTRY),
    .DATA_W  (DATA_W)
  ) u_engine (
    .clk         (clk),
    .arst_n      (arst_n),
    .s0_valid    (s0_valid),
    .s0_push     (s0_push),
    .s0_ctxt     (s0_ctxt),
    .s0_data     (s0_data),
    .empty_next  (empty_next),
    .full_next   (full_next),
    .lkup_pass_r (lkup_pass_r),
    .lkup_op_r   (lkup_op_r),
    .lkup_addr_r (lkup_addr_r),
    .lkup_data_r (lkup_data_r),
    .empty_r     (empty_r),
    .full_r      (full_r)
  );

endmodule

// File: tb/ll_queue_checker.sv
/*
 * Reference model and checks for the linked-list queue controller
 * Per-context slot queues, lowest-first free set and a two-edge delay line
 */

module ll_queue_checker
  import ll_queue_pkg::*;
#(
  parameter int N_CTXT  = DEFAULT_N_CTXT,
  parameter int N_ENTRY = DEFAULT_N_ENTRY,
  parameter int DATA_W  = DEFAULT_DATA_W
)
(
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       cmd_pass,
  input  logic                       cmd_push,
  input  logic [$clog2(N_CTXT)-1:0]  cmd_ctxt,
  input  logic [DATA_W-1:0]          cmd_data,
  input  logic                       cmd_accept,
  input  logic                       lkup_pass_r,
  input  lkup_op_t                   lkup_op_r,
  input  logic [$clog2(N_ENTRY)-1:0] lkup_addr_r,
  input  logic [DATA_W-1:0]          lkup_data_r,
  input  logic [N_CTXT-1:0]          empty_r,
  input  logic                       full_r,
  output logic                       failed
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int ADDR_W = $clog2(N_ENTRY);

  // Slots held by each context in push order
  logic [ADDR_W-1:0] slot_q [N_CTXT][$];
  logic              busy_m [N_ENTRY];
  int                used;

  // Index 0 holds the newest accepted command
  // Index 1 holds the command due on the lookup port
  logic              d_valid [2];
  lkup_op_t          d_op    [2];
  logic [ADDR_W-1:0] d_addr  [2];
  logic [DATA_W-1:0] d_data  [2];
  logic [N_CTXT-1:0] d_empty [2];
  logic              d_full  [2];

  function automatic logic [ADDR_W-1:0] lowest_free();
    for (int i = 0; i < N_ENTRY; i++)
    begin
      if (!busy_m[i])
      begin
        return ADDR_W'(i);
      end
    end
    return '0;
  endfunction

  function automatic logic [N_CTXT-1:0] model_empty();
    logic [N_CTXT-1:0] e;
    for (int c = 0; c < N_CTXT; c++)
    begin
      e[c] = (slot_q[c].size() == 0);
    end
    return e;
  endfunction

  // Only the first mismatch gets an error line
  task automatic report_mismatch(input string name, input logic [63:0] exp,
                                 input logic [63:0] act);
    if (!failed)
    begin
      $display("Error at time %0t: %s expected 0x%0h, actual 0x%0h", $time, name, exp, act);
    end
    failed = 1'b1;
  endtask

  always @(posedge clk)
  begin
    logic              exp_accept;
    logic [ADDR_W-1:0] slot;
    if (!arst_n)
    begin
      failed = 1'b0;
      used   = 0;
      for (int c = 0; c < N_CTXT; c++)
      begin
        slot_q[c].delete();
      end
      for (int i = 0; i < N_ENTRY; i++)
      begin
        busy_m[i] = 1'b0;
      end
      for (int k = 0; k < 2; k++)
      begin
        d_valid[k] = 1'b0;
        d_empty[k] = '1;
        d_full[k]  = 1'b0;
      end
    end
    else
    begin
      // Lookup pulse exactly two edges after acceptance
      assert (lkup_pass_r == d_valid[1])
        else report_mismatch("lkup_pass_r", 64'(d_valid[1]), 64'(lkup_pass_r));
      if (d_valid[1])
      begin
        assert (lkup_op_r == d_op[1])
          else report_mismatch("lkup_op_r", 64'(d_op[1]), 64'(lkup_op_r));
        assert (lkup_addr_r == d_addr[1])
          else report_mismatch("lkup_addr_r", 64'(d_addr[1]), 64'(lkup_addr_r));
        if (d_op[1] == LKUP_WRITE)
        begin
          assert (lkup_data_r == d_data[1])
            else report_mismatch("lkup_data_r", 64'(d_data[1]), 64'(lkup_data_r));
        end
      end
      // Status of every completed command
      assert (empty_r == d_empty[1])
        else report_mismatch("empty_r", 64'(d_empty[1]), 64'(empty_r));
      assert (full_r == d_full[1])
        else report_mismatch("full_r", 64'(d_full[1]), 64'(full_r));

      // Model already holds every accepted command
      if (cmd_push)
      begin
        exp_accept = (used < N_ENTRY);
      end
      else
      begin
        exp_accept = (slot_q[cmd_ctxt].size() != 0);
      end
      assert (cmd_accept == exp_accept)
        else report_mismatch("cmd_accept", 64'(exp_accept), 64'(cmd_accept));

      d_valid[1] = d_valid[0];
      d_op[1]    = d_op[0];
      d_addr[1]  = d_addr[0];
      d_data[1]  = d_data[0];
      d_empty[1] = d_empty[0];
      d_full[1]  = d_full[0];

      d_valid[0] = cmd_pass & exp_accept;
      if (d_valid[0] && cmd_push)
      begin
        // Lowest free slot joins the tail of the queue
        slot = lowest_free();
        busy_m[slot] = 1'b1;
        used++;
        slot_q[cmd_ctxt].push_back(slot);
        d_op[0]   = LKUP_WRITE;
        d_addr[0] = slot;
        d_data[0] = cmd_data;
      end
      else if (d_valid[0])
      begin
        // Head slot leaves and returns to the free set
        slot = slot_q[cmd_ctxt].pop_front();
        busy_m[slot] = 1'b0;
        used--;
        d_op[0]   = LKUP_READ;
        d_addr[0] = slot;
      end
      d_empty[0] = model_empty();
      d_full[0]  = (used == N_ENTRY);
    end
  end

endmodule

// File: tb/ll_queue_tb.sv
/*
 * Testbench for the linked-list queue controller
 * Random push/pop traffic with fill and drain phases
 * Results checked by ll_queue_checker
 */

module ll_queue_tb
  import ll_queue_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_CTXT     = DEFAULT_N_CTXT;
  localparam int N_ENTRY    = DEFAULT_N_ENTRY;
  localparam int DATA_W     = DEFAULT_DATA_W;
  localparam int CTXT_W     = $clog2(N_CTXT);
  localparam int ADDR_W     = $clog2(N_ENTRY);
  localparam int N_CMD      = 600;
  // Two cycles per command at most, one idle cycle each at most, plus reset
  localparam int MAX_CYCLES = 2000;

  logic              clk = 1'b0;
  logic              arst_n;
  logic              cmd_pass;
  logic              cmd_push;
  logic [CTXT_W-1:0] cmd_ctxt;
  logic [DATA_W-1:0] cmd_data;
  logic              cmd_accept;
  logic              lkup_pass_r;
  lkup_op_t          lkup_op_r;
  logic [ADDR_W-1:0] lkup_addr_r;
  logic [DATA_W-1:0] lkup_data_r;
  logic [N_CTXT-1:0] empty_r;
  logic              full_r;
  logic              check_failed;

  int seed;
  int cycles = 0;
  int push_refusals = 0;
  int pop_refusals = 0;

  always #5 clk = ~clk;

  ll_queue_top #(
    .N_CTXT  (N_CTXT),
    .N_ENTRY (N_ENTRY),
    .DATA_W  (DATA_W)
  ) dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_pass    (cmd_pass),
    .cmd_push    (cmd_push),
    .cmd_ctxt    (cmd_ctxt),
    .cmd_data    (cmd_data),
    .cmd_accept  (cmd_accept),
    .lkup_pass_r (lkup_pass_r),
    .lkup_op_r   (lkup_op_r),
    .lkup_addr_r (lkup_addr_r),
    .lkup_data_r (lkup_data_r),
    .empty_r     (empty_r),
    .full_r      (full_r)
  );

  ll_queue_checker #(
    .N_CTXT  (N_CTXT),
    .N_ENTRY (N_ENTRY),
    .DATA_W  (DATA_W)
  ) u_checker (
    .clk         (clk),
    .arst_n      (arst_n),
    .cmd_pass    (cmd_pass),
    .cmd_push    (cmd_push),
    .cmd_ctxt    (cmd_ctxt),
    .cmd_data    (cmd_data),
    .cmd_accept  (cmd_accept),
    .lkup_pass_r (lkup_pass_r),
    .lkup_op_r   (lkup_op_r),
    .lkup_addr_r (lkup_addr_r),
    .lkup_data_r (lkup_data_r),
    .empty_r     (empty_r),
    .full_r      (full_r),
    .failed      (check_failed)
  );

  always @(posedge check_failed)
  begin
    $display("SIMULATION FAILED");
    $fatal(1, "Checker found a mismatch");
  end

  always @(posedge clk)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $fatal(1, "Timeout");
    end
  end

  // Offer one command
  // A refused command is held one more cycle and then withdrawn
  task automatic issue(input logic push, input logic [CTXT_W-1:0] ctxt);
    @(negedge clk);
    cmd_pass = 1'b1;
    cmd_push = push;
    cmd_ctxt = ctxt;
    cmd_data = DATA_W'($random(seed));
    @(posedge clk);
    if (!cmd_accept)
    begin
      if (push)
      begin
        push_refusals++;
      end
      else
      begin
        pop_refusals++;
      end
      @(posedge clk);
    end
  endtask

  task automatic idle();
    @(negedge clk);
    cmd_pass = 1'b0;
  endtask

  initial
  begin
    logic [31:0]       roll;
    logic              push;
    logic [CTXT_W-1:0] ctxt;
    seed     = 32'h64fa_fb21;
    arst_n   = 1'b0;
    cmd_pass = 1'b0;
    cmd_push = 1'b0;
    cmd_ctxt = '0;
    cmd_data = '0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // Push then pop on one context back to back
    issue(1'b1, '0);
    issue(1'b0, '0);

    for (int i = 0; i < N_CMD; i++)
    begin
      roll = $random(seed);
      ctxt = CTXT_W'(roll[15:8] % N_CTXT);
      if (i < 200)
      begin
        push = (roll % 8) < 5;
      end
      else if (i < 300)
      begin
        // Fill phase runs the pool full so pushes bounce
        push = 1'b1;
      end
      else if (i < 400)
      begin
        // Drain phase visits the contexts in turn
        push = 1'b0;
        ctxt = CTXT_W'(i % N_CTXT);
      end
      else
      begin
        push = roll[0];
      end
      issue(push, ctxt);
      if (roll[23:20] == 4'h0)
      begin
        idle();
      end
    end
    idle();

    // Last lookup lands two edges after the final acceptance
    repeat (3) @(posedge clk);
    if (push_refusals == 0 || pop_refusals == 0)
    begin
      $display("Stimulus never reached both a refused push and a refused pop");
      $display("SIMULATION FAILED");
      $fatal(1, "Run ended with failures");
    end
    else
    begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule
